// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

	// first fetch address
	localparam logic [31:0] resetPc = 32'h8000_0000;

	// major opcodes
	localparam logic [6:0] opcLui = 7'b0110111;
	localparam logic [6:0] opcAuipc = 7'b0010111;
	localparam logic [6:0] opcJal = 7'b1101111;
	localparam logic [6:0] opcJalr = 7'b1100111;
	localparam logic [6:0] opcBranch = 7'b1100011;
	localparam logic [6:0] opcLoad = 7'b0000011;
	localparam logic [6:0] opcStore = 7'b0100011;
	localparam logic [6:0] opcOpImm = 7'b0010011;
	localparam logic [6:0] opcOp = 7'b0110011;
	localparam logic [6:0] opcSystem = 7'b1110011;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
		aluSrl, aluSra, aluOr, aluAnd, aluPassB
	} aluOpT;

	// brNone with pcSelBranch means an unconditional jump
	typedef enum logic [2:0] {brNone, brEq, brNe, brLt, brGe, brLtu, brGeu} branchKindT;

	typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} accessSizeT;

	typedef enum logic [1:0] {wbAlu, wbLoad, wbPcPlus4, wbPcPlusImm} wbSelT;

	typedef enum logic [1:0] {pcSelPlus4, pcSelBranch, pcSelJumpReg} pcSelT;

	// decoded control, 20 bits
	typedef struct packed {
		aluOpT aluOp;
		logic srcBImm;
		logic srcAPc;
		branchKindT branchKind;
		pcSelT pcSel;
		wbSelT wbSel;
		logic regWrite;
		logic memRead;
		logic memWrite;
		accessSizeT accessSize;
		logic loadUnsigned;
		logic isEbreak;
	} ctrlT;

endpackage

`default_nettype wire

// File: src/busPkg.sv
`default_nettype none

package busPkg;

	// one select bit per byte lane
	localparam int selWidth = 4;

	// wishbone classic master side
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [selWidth-1:0] sel;
		logic [31:0] adr;
		logic [31:0] datW;
	} wbReqT;

	// slave side, ack is the only back-pressure
	typedef struct packed {
		logic ack;
		logic [31:0] datR;
	} wbRspT;

endpackage

`default_nettype wire

// File: src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder (
	input wire [31:0] instr,
	output rvPkg::ctrlT ctrl,
	output logic [31:0] imm,
	output logic invalid
);
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic [31:0] immI;
	logic [31:0] immS;
	logic [31:0] immB;
	logic [31:0] immU;
	logic [31:0] immJ;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	// immediate formats, all sign extended from bit 31
	assign immI = {{20{instr[31]}}, instr[31:20]};
	assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign immU = {instr[31:12], 12'b0};
	assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		// defaults: add, no branch, pc+4, alu write-back, nothing enabled
		ctrl = '0;
		imm = immI;
		invalid = 1'b0;
		case (opcode)
			rvPkg::opcLui: begin
				imm = immU;
				ctrl.aluOp = rvPkg::aluPassB;
				ctrl.srcBImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			rvPkg::opcAuipc: begin
				// alu sees pc+imm too, write-back takes the control adder
				imm = immU;
				ctrl.srcAPc = 1'b1;
				ctrl.srcBImm = 1'b1;
				ctrl.wbSel = rvPkg::wbPcPlusImm;
				ctrl.regWrite = 1'b1;
			end
			rvPkg::opcJal: begin
				imm = immJ;
				ctrl.pcSel = rvPkg::pcSelBranch;
				ctrl.wbSel = rvPkg::wbPcPlus4;
				ctrl.regWrite = 1'b1;
			end
			rvPkg::opcJalr: begin
				ctrl.srcBImm = 1'b1;
				ctrl.pcSel = rvPkg::pcSelJumpReg;
				ctrl.wbSel = rvPkg::wbPcPlus4;
				ctrl.regWrite = 1'b1;
				invalid = (funct3 != 3'd0);
			end
			rvPkg::opcBranch: begin
				imm = immB;
				ctrl.pcSel = rvPkg::pcSelBranch;
				// eq/ne test zero after sub, the rest test bit 0 of slt/sltu
				case (funct3)
					3'd0: {ctrl.branchKind, ctrl.aluOp} = {rvPkg::brEq, rvPkg::aluSub};
					3'd1: {ctrl.branchKind, ctrl.aluOp} = {rvPkg::brNe, rvPkg::aluSub};
					3'd4: {ctrl.branchKind, ctrl.aluOp} = {rvPkg::brLt, rvPkg::aluSlt};
					3'd5: {ctrl.branchKind, ctrl.aluOp} = {rvPkg::brGe, rvPkg::aluSlt};
					3'd6: {ctrl.branchKind, ctrl.aluOp} = {rvPkg::brLtu, rvPkg::aluSltu};
					3'd7: {ctrl.branchKind, ctrl.aluOp} = {rvPkg::brGeu, rvPkg::aluSltu};
					default: invalid = 1'b1;
				endcase
			end
			rvPkg::opcLoad: begin
				ctrl.srcBImm = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.wbSel = rvPkg::wbLoad;
				ctrl.loadUnsigned = funct3[2];
				case (funct3)
					3'd0, 3'd4: ctrl.accessSize = rvPkg::sizeByte;
					3'd1, 3'd5: ctrl.accessSize = rvPkg::sizeHalf;
					3'd2: ctrl.accessSize = rvPkg::sizeWord;
					default: invalid = 1'b1;
				endcase
			end
			rvPkg::opcStore: begin
				imm = immS;
				ctrl.srcBImm = 1'b1;
				ctrl.memWrite = 1'b1;
				case (funct3)
					3'd0: ctrl.accessSize = rvPkg::sizeByte;
					3'd1: ctrl.accessSize = rvPkg::sizeHalf;
					3'd2: ctrl.accessSize = rvPkg::sizeWord;
					default: invalid = 1'b1;
				endcase
			end
			rvPkg::opcOpImm: begin
				ctrl.srcBImm = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct3)
					3'd0: ctrl.aluOp = rvPkg::aluAdd;
					3'd2: ctrl.aluOp = rvPkg::aluSlt;
					3'd3: ctrl.aluOp = rvPkg::aluSltu;
					3'd4: ctrl.aluOp = rvPkg::aluXor;
					3'd6: ctrl.aluOp = rvPkg::aluOr;
					3'd7: ctrl.aluOp = rvPkg::aluAnd;
					3'd1: begin
						// shamt is five bits, upper field must be clear
						ctrl.aluOp = rvPkg::aluSll;
						invalid = (funct7 != 7'h00);
					end
					default: begin
						ctrl.aluOp = funct7[5] ? rvPkg::aluSra : rvPkg::aluSrl;
						invalid = (funct7 != 7'h00) && (funct7 != 7'h20);
					end
				endcase
			end
			rvPkg::opcOp: begin
				ctrl.regWrite = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'd0}: ctrl.aluOp = rvPkg::aluAdd;
					{7'h20, 3'd0}: ctrl.aluOp = rvPkg::aluSub;
					{7'h00, 3'd1}: ctrl.aluOp = rvPkg::aluSll;
					{7'h00, 3'd2}: ctrl.aluOp = rvPkg::aluSlt;
					{7'h00, 3'd3}: ctrl.aluOp = rvPkg::aluSltu;
					{7'h00, 3'd4}: ctrl.aluOp = rvPkg::aluXor;
					{7'h00, 3'd5}: ctrl.aluOp = rvPkg::aluSrl;
					{7'h20, 3'd5}: ctrl.aluOp = rvPkg::aluSra;
					{7'h00, 3'd6}: ctrl.aluOp = rvPkg::aluOr;
					{7'h00, 3'd7}: ctrl.aluOp = rvPkg::aluAnd;
					default: invalid = 1'b1;
				endcase
			end
			rvPkg::opcSystem: begin
				// only ebreak, exact word
				ctrl.isEbreak = (instr == 32'h0010_0073);
				invalid = (instr != 32'h0010_0073);
			end
			default: invalid = 1'b1;
		endcase
	end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input wire clk,
	input wire reset,
	input wire [4:0] rs1,
	input wire [4:0] rs2,
	input wire [4:0] rd,
	input wire writeEnable,
	input wire [31:0] writeData,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data
);
	// x1..x31, x0 has no storage
	logic [31:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && rd != 5'd0) begin
			regs[rd] <= writeData;
		end
	end

	// combinational reads, x0 reads zero
	assign rs1Data = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
	assign rs2Data = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// File: src/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input wire rvPkg::aluOpT op,
	input wire [31:0] a,
	input wire [31:0] b,
	output logic [31:0] result,
	output logic zero
);
	logic [4:0] shamt;

	// shifts use the low five bits of b only
	assign shamt = b[4:0];

	always_comb begin
		case (op)
			rvPkg::aluSub: result = a - b;
			rvPkg::aluSll: result = a << shamt;
			rvPkg::aluSlt: result = {31'd0, $signed(a) < $signed(b)};
			rvPkg::aluSltu: result = {31'd0, a < b};
			rvPkg::aluXor: result = a ^ b;
			rvPkg::aluSrl: result = a >> shamt;
			rvPkg::aluSra: result = $unsigned($signed(a) >>> shamt);
			rvPkg::aluOr: result = a | b;
			rvPkg::aluAnd: result = a & b;
			// lui passes the upper immediate through
			rvPkg::aluPassB: result = b;
			default: result = a + b;
		endcase
	end

	// eq/ne branches look at this after sub
	assign zero = (result == 32'd0);

endmodule

`default_nettype wire

// File: src/loadStoreAlign.sv
`timescale 1ns/1ns
`default_nettype none

module loadStoreAlign (
	input wire [1:0] addrLow,
	input wire rvPkg::accessSizeT size,
	input wire loadUnsigned,
	input wire [31:0] storeData,
	output logic [busPkg::selWidth-1:0] sel,
	output logic [31:0] storeDataLanes,
	input wire [31:0] readLanes,
	output logic [31:0] loadData
);
	logic [7:0] laneByte;
	logic [15:0] laneHalf;

	// store side: replicate, the select picks the lanes
	always_comb begin
		case (size)
			rvPkg::sizeByte: begin
				storeDataLanes = {4{storeData[7:0]}};
				sel = 4'b0001 << addrLow;
			end
			rvPkg::sizeHalf: begin
				storeDataLanes = {2{storeData[15:0]}};
				sel = addrLow[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				storeDataLanes = storeData;
				sel = 4'b1111;
			end
		endcase
	end

	// load side: pick addressed lane
	assign laneByte = readLanes[8*addrLow +: 8];
	assign laneHalf = addrLow[1] ? readLanes[31:16] : readLanes[15:0];

	// then sign or zero extend
	always_comb begin
		case (size)
			rvPkg::sizeByte: loadData = {{24{laneByte[7] & ~loadUnsigned}}, laneByte};
			rvPkg::sizeHalf: loadData = {{16{laneHalf[15] & ~loadUnsigned}}, laneHalf};
			default: loadData = readLanes;
		endcase
	end

endmodule

`default_nettype wire

// File: src/coreControl.sv
`timescale 1ns/1ns
`default_nettype none

module coreControl (
	input wire clk,
	input wire reset,
	input wire rvPkg::ctrlT ctrl,
	input wire invalidInstr,
	input wire [31:0] imm,
	input wire [31:0] rs1Data,
	input wire [31:0] aluResult,
	input wire aluZero,
	input wire [busPkg::selWidth-1:0] sel,
	input wire [31:0] storeDataLanes,
	input wire [31:0] loadData,
	input wire busPkg::wbRspT wbRsp,
	output busPkg::wbReqT wbReq,
	output logic [31:0] instr,
	output logic [31:0] pc,
	output logic regWriteEnable,
	output logic [31:0] regWriteData,
	output logic halted,
	output logic invalid
);
	typedef enum logic [1:0] {stFetch, stExecute, stMemory, stStopped} stateT;

	stateT state;
	logic busDone;
	logic isMem;
	logic stopNow;
	logic taken;
	logic [31:0] pcPlus4;
	logic [31:0] pcPlusImm;
	logic [31:0] jumpTarget;
	logic [31:0] nextPc;

	// ack sampled while a cycle is open
	assign busDone = wbReq.cyc & wbRsp.ack;
	assign isMem = ctrl.memRead | ctrl.memWrite;
	assign stopNow = invalidInstr | ctrl.isEbreak;
	assign pcPlus4 = pc + 32'd4;
	assign pcPlusImm = pc + imm;
	// jalr target, bit 0 cleared
	assign jumpTarget = (rs1Data + imm) & ~32'd1;

	// branch decision from alu flags
	always_comb begin
		case (ctrl.branchKind)
			rvPkg::brEq: taken = aluZero;
			rvPkg::brNe: taken = ~aluZero;
			rvPkg::brLt, rvPkg::brLtu: taken = aluResult[0];
			rvPkg::brGe, rvPkg::brGeu: taken = ~aluResult[0];
			// jal
			default: taken = 1'b1;
		endcase
	end

	always_comb begin
		case (ctrl.pcSel)
			rvPkg::pcSelBranch: nextPc = taken ? pcPlusImm : pcPlus4;
			rvPkg::pcSelJumpReg: nextPc = jumpTarget;
			default: nextPc = pcPlus4;
		endcase
	end

	// write-back source
	always_comb begin
		case (ctrl.wbSel)
			rvPkg::wbLoad: regWriteData = loadData;
			rvPkg::wbPcPlus4: regWriteData = pcPlus4;
			rvPkg::wbPcPlusImm: regWriteData = pcPlusImm;
			default: regWriteData = aluResult;
		endcase
	end

	// non-memory ops write at end of execute, loads on their ack edge
	assign regWriteEnable = ctrl.regWrite &&
		((state == stExecute && !isMem && !stopNow) ||
		(state == stMemory && busDone && ctrl.memRead));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= stFetch;
			pc <= rvPkg::resetPc;
			wbReq <= '0;
			halted <= 1'b0;
			invalid <= 1'b0;
		end else begin
			case (state)
				stFetch: begin
					// raise one cycle after entry, hold until ack
					if (!wbReq.cyc) begin
						wbReq <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, sel: '1, adr: pc, datW: '0};
					end else if (busDone) begin
						wbReq.cyc <= 1'b0;
						wbReq.stb <= 1'b0;
						state <= stExecute;
					end
				end
				stExecute: begin
					if (stopNow) begin
						// pc stays on the stopping instruction
						halted <= 1'b1;
						invalid <= invalidInstr;
						state <= stStopped;
					end else if (isMem) begin
						state <= stMemory;
					end else begin
						pc <= nextPc;
						state <= stFetch;
					end
				end
				stMemory: begin
					// address and lanes stay stable, instr is held
					if (!wbReq.cyc) begin
						wbReq <= '{cyc: 1'b1, stb: 1'b1, we: ctrl.memWrite, sel: sel,
							adr: aluResult, datW: storeDataLanes};
					end else if (busDone) begin
						wbReq.cyc <= 1'b0;
						wbReq.stb <= 1'b0;
						pc <= pcPlus4;
						state <= stFetch;
					end
				end
				// stopped until reset, no more bus cycles
				default: state <= stStopped;
			endcase
		end
	end

	// instruction register, latched on the fetch ack edge
	always_ff @(posedge clk) begin
		if (state == stFetch && busDone) begin
			instr <= wbRsp.datR;
		end
	end

endmodule

`default_nettype wire

// File: src/rvCoreTop.sv
`timescale 1ns/1ns
`default_nettype none

module rvCoreTop (
	input wire clk,
	input wire reset,
	output busPkg::wbReqT wbReq,
	input wire busPkg::wbRspT wbRsp,
	output logic [31:0] pc,
	output logic halted,
	output logic invalid
);
	rvPkg::ctrlT ctrl;
	logic [31:0] instr;
	logic [31:0] imm;
	logic decInvalid;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic regWriteEnable;
	logic [31:0] regWriteData;
	logic [31:0] srcA;
	logic [31:0] srcB;
	logic [31:0] aluResult;
	logic aluZero;
	logic [busPkg::selWidth-1:0] sel;
	logic [31:0] storeDataLanes;
	logic [31:0] loadData;

	// operand selects
	assign srcA = ctrl.srcAPc ? pc : rs1Data;
	assign srcB = ctrl.srcBImm ? imm : rs2Data;

	coreControl coreControl_i (
		.clk(clk),
		.reset(reset),
		.ctrl(ctrl),
		.invalidInstr(decInvalid),
		.imm(imm),
		.rs1Data(rs1Data),
		.aluResult(aluResult),
		.aluZero(aluZero),
		.sel(sel),
		.storeDataLanes(storeDataLanes),
		.loadData(loadData),
		.wbRsp(wbRsp),
		.wbReq(wbReq),
		.instr(instr),
		.pc(pc),
		.regWriteEnable(regWriteEnable),
		.regWriteData(regWriteData),
		.halted(halted),
		.invalid(invalid)
	);

	instrDecoder instrDecoder_i (
		.instr(instr),
		.ctrl(ctrl),
		.imm(imm),
		.invalid(decInvalid)
	);

	// register fields straight from the instruction register
	regFile regFile_i (
		.clk(clk),
		.reset(reset),
		.rs1(instr[19:15]),
		.rs2(instr[24:20]),
		.rd(instr[11:7]),
		.writeEnable(regWriteEnable),
		.writeData(regWriteData),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data)
	);

	alu alu_i (
		.op(ctrl.aluOp),
		.a(srcA),
		.b(srcB),
		.result(aluResult),
		.zero(aluZero)
	);

	// low address bits pick byte lanes, read data comes straight off the bus
	loadStoreAlign loadStoreAlign_i (
		.addrLow(aluResult[1:0]),
		.size(ctrl.accessSize),
		.loadUnsigned(ctrl.loadUnsigned),
		.storeData(rs2Data),
		.sel(sel),
		.storeDataLanes(storeDataLanes),
		.readLanes(wbRsp.datR),
		.loadData(loadData)
	);

endmodule

`default_nettype wire

// File: dv/tbTests.svh
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

// instruction encoders
function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
	return {f7, rs2, rs1, f3, rd, rvPkg::opcOp};
endfunction

function automatic logic [31:0] encI(input logic [31:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
	return {imm[11:0], rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] encS(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::opcStore};
endfunction

function automatic logic [31:0] encB(input logic [31:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::opcBranch};
endfunction

function automatic logic [31:0] encU(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opc);
	return {imm, rd, opc};
endfunction

function automatic logic [31:0] encJ(input logic [31:0] imm, input logic [4:0] rd);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opcJal};
endfunction

function automatic logic [31:0] addrOf(input int index);
	return rvPkg::resetPc + 32'(4 * index);
endfunction

// new program, x10 holds the data base
task automatic startProgram();
	prog.delete();
	expOff.delete();
	expVal.delete();
	storeOff = 0;
	testErrors = 0;
	prog.push_back(encU(dataBase[31:12], 5'd10, rvPkg::opcLui));
endtask

// sw rs to the next result slot and remember what it must hold
task automatic storeCheck(input logic [4:0] rs, input logic [31:0] expected);
	prog.push_back(encS(32'(storeOff), rs, 5'd10, 3'd2));
	expOff.push_back(storeOff);
	expVal.push_back(expected);
	storeOff += 4;
endtask

task automatic reportMismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
	$display("MISMATCH %s got %h expected %h", name, got, expected);
	testErrors++;
endtask

// load, reset, wait for halt, then check stop state and result words
task automatic runProgram(input int stopIndex, input logic expInvalid);
	for (int i = 0; i < memWords; i++) begin
		mem[i] = addrOf(i) ^ 32'hC3A5_0F96;
	end
	foreach (prog[i]) mem[i] = prog[i];
	@(posedge clk);
	#1;
	reset = 1'b1;
	repeat (5) @(posedge clk);
	#1;
	reset = 1'b0;
	while (!halted) begin
		@(posedge clk);
		#1;
	end
	if (invalid != expInvalid)
		reportMismatch("invalid", 32'(invalid), 32'(expInvalid));
	if (pc != addrOf(stopIndex))
		reportMismatch("pc", pc, addrOf(stopIndex));
	foreach (expOff[k]) begin
		if (mem[memIndex(dataBase + 32'(expOff[k]))] != expVal[k])
			reportMismatch($sformatf("mem[%h]", dataBase + 32'(expOff[k])),
				mem[memIndex(dataBase + 32'(expOff[k]))], expVal[k]);
	end
endtask

task automatic finishTest(input string name);
	testsRun++;
	errors += testErrors;
	if (testErrors == 0) begin
		$display("test %s: ok", name);
	end else begin
		testsFailed++;
		$display("test %s: %0d errors", name, testErrors);
	end
endtask

task automatic stopWithEbreak();
	int idx;
	idx = prog.size();
	prog.push_back(32'h0010_0073);
	runProgram(idx, 1'b0);
endtask

task automatic arithTest();
	int idx;
	startProgram();
	// x1 = -5, x2 = 3
	prog.push_back(encI(-5, 5'd0, 3'd0, 5'd1, rvPkg::opcOpImm));
	prog.push_back(encI(3, 5'd0, 3'd0, 5'd2, rvPkg::opcOpImm));
	prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd0, 5'd3));
	storeCheck(5'd3, 32'hFFFF_FFFE);
	prog.push_back(encR(7'h20, 5'd2, 5'd1, 3'd0, 5'd3));
	storeCheck(5'd3, 32'hFFFF_FFF8);
	// shamt from x1 low bits is 27
	prog.push_back(encR(7'h00, 5'd1, 5'd2, 3'd1, 5'd3));
	storeCheck(5'd3, 32'h1800_0000);
	prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd2, 5'd3));
	storeCheck(5'd3, 32'h0000_0001);
	prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd3, 5'd3));
	storeCheck(5'd3, 32'h0000_0000);
	prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd4, 5'd3));
	storeCheck(5'd3, 32'hFFFF_FFF8);
	prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd5, 5'd3));
	storeCheck(5'd3, 32'h1FFF_FFFF);
	prog.push_back(encR(7'h20, 5'd2, 5'd1, 3'd5, 5'd3));
	storeCheck(5'd3, 32'hFFFF_FFFF);
	prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd6, 5'd3));
	storeCheck(5'd3, 32'hFFFF_FFFB);
	prog.push_back(encR(7'h00, 5'd2, 5'd1, 3'd7, 5'd3));
	storeCheck(5'd3, 32'h0000_0003);
	// immediate forms
	prog.push_back(encI(4, 5'd2, 3'd1, 5'd3, rvPkg::opcOpImm));
	storeCheck(5'd3, 32'h0000_0030);
	prog.push_back(encI(32'h401, 5'd1, 3'd5, 5'd3, rvPkg::opcOpImm));
	storeCheck(5'd3, 32'hFFFF_FFFD);
	prog.push_back(encI(-4, 5'd1, 3'd2, 5'd3, rvPkg::opcOpImm));
	storeCheck(5'd3, 32'h0000_0001);
	prog.push_back(encI(-1, 5'd2, 3'd3, 5'd3, rvPkg::opcOpImm));
	storeCheck(5'd3, 32'h0000_0001);
	prog.push_back(encI(32'hF0, 5'd1, 3'd4, 5'd3, rvPkg::opcOpImm));
	storeCheck(5'd3, 32'hFFFF_FF0B);
	prog.push_back(encI(32'h700, 5'd2, 3'd6, 5'd3, rvPkg::opcOpImm));
	storeCheck(5'd3, 32'h0000_0703);
	prog.push_back(encI(32'h7F, 5'd1, 3'd7, 5'd3, rvPkg::opcOpImm));
	storeCheck(5'd3, 32'h0000_007B);
	prog.push_back(encU(20'h12345, 5'd3, rvPkg::opcLui));
	storeCheck(5'd3, 32'h1234_5000);
	idx = prog.size();
	prog.push_back(encU(20'h00001, 5'd3, rvPkg::opcAuipc));
	storeCheck(5'd3, addrOf(idx) + 32'h1000);
	stopWithEbreak();
	finishTest("arithmetic");
endtask

task automatic memoryTest();
	startProgram();
	// x1 = 0x8899aabb, x2 = 0xc4
	prog.push_back(encU(20'h8899B, 5'd1, rvPkg::opcLui));
	prog.push_back(encI(32'hFFFF_FABB, 5'd1, 3'd0, 5'd1, rvPkg::opcOpImm));
	prog.push_back(encI(32'hC4, 5'd0, 3'd0, 5'd2, rvPkg::opcOpImm));
	prog.push_back(encS(32'h100, 5'd1, 5'd10, 3'd2));
	// bytes on every lane
	prog.push_back(encS(32'h104, 5'd2, 5'd10, 3'd0));
	prog.push_back(encS(32'h105, 5'd1, 5'd10, 3'd0));
	prog.push_back(encS(32'h106, 5'd2, 5'd10, 3'd0));
	prog.push_back(encS(32'h107, 5'd1, 5'd10, 3'd0));
	// halves on both lanes
	prog.push_back(encS(32'h108, 5'd1, 5'd10, 3'd1));
	prog.push_back(encS(32'h10A, 5'd2, 5'd10, 3'd1));
	prog.push_back(encI(32'h101, 5'd10, 3'd0, 5'd3, rvPkg::opcLoad));
	storeCheck(5'd3, 32'hFFFF_FFAA);
	prog.push_back(encI(32'h103, 5'd10, 3'd4, 5'd3, rvPkg::opcLoad));
	storeCheck(5'd3, 32'h0000_0088);
	prog.push_back(encI(32'h102, 5'd10, 3'd1, 5'd3, rvPkg::opcLoad));
	storeCheck(5'd3, 32'hFFFF_8899);
	prog.push_back(encI(32'h100, 5'd10, 3'd5, 5'd3, rvPkg::opcLoad));
	storeCheck(5'd3, 32'h0000_AABB);
	prog.push_back(encI(32'h104, 5'd10, 3'd2, 5'd3, rvPkg::opcLoad));
	storeCheck(5'd3, 32'hBBC4_BBC4);
	prog.push_back(encI(32'h10A, 5'd10, 3'd0, 5'd3, rvPkg::opcLoad));
	storeCheck(5'd3, 32'hFFFF_FFC4);
	// the three store targets themselves
	expOff.push_back(32'h100);
	expVal.push_back(32'h8899_AABB);
	expOff.push_back(32'h104);
	expVal.push_back(32'hBBC4_BBC4);
	expOff.push_back(32'h108);
	expVal.push_back(32'h00C4_AABB);
	stopWithEbreak();
	finishTest("memory");
endtask

// branch over the next instruction, which adds incr to x5
task automatic branchPair(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input int incr);
	prog.push_back(encB(8, rs2, rs1, f3));
	prog.push_back(encI(32'(incr), 5'd5, 3'd0, 5'd5, rvPkg::opcOpImm));
endtask

task automatic controlFlowTest();
	int j;
	int a;
	startProgram();
	prog.push_back(encI(-1, 5'd0, 3'd0, 5'd1, rvPkg::opcOpImm));
	prog.push_back(encI(1, 5'd0, 3'd0, 5'd2, rvPkg::opcOpImm));
	// taken, skipped adds would spoil the count
	branchPair(3'd0, 5'd1, 5'd1, 16);
	branchPair(3'd1, 5'd1, 5'd2, 16);
	branchPair(3'd4, 5'd1, 5'd2, 16);
	branchPair(3'd5, 5'd2, 5'd1, 16);
	branchPair(3'd6, 5'd2, 5'd1, 16);
	branchPair(3'd7, 5'd1, 5'd2, 16);
	// not taken, each adds one
	branchPair(3'd0, 5'd1, 5'd2, 1);
	branchPair(3'd1, 5'd1, 5'd1, 1);
	branchPair(3'd4, 5'd2, 5'd1, 1);
	branchPair(3'd5, 5'd1, 5'd2, 1);
	branchPair(3'd6, 5'd1, 5'd2, 1);
	branchPair(3'd7, 5'd2, 5'd1, 1);
	j = prog.size();
	prog.push_back(encJ(8, 5'd6));
	prog.push_back(encI(16, 5'd5, 3'd0, 5'd5, rvPkg::opcOpImm));
	// odd jalr target, bit zero dropped
	a = prog.size();
	prog.push_back(encU(20'h0, 5'd7, rvPkg::opcAuipc));
	prog.push_back(encI(13, 5'd7, 3'd0, 5'd8, rvPkg::opcJalr));
	prog.push_back(encI(16, 5'd5, 3'd0, 5'd5, rvPkg::opcOpImm));
	storeCheck(5'd5, 32'd6);
	storeCheck(5'd6, addrOf(j) + 32'd4);
	storeCheck(5'd8, addrOf(a) + 32'd8);
	stopWithEbreak();
	finishTest("control flow");
endtask

task automatic ebreakTest();
	int busCycles;
	startProgram();
	prog.push_back(encI(7, 5'd0, 3'd0, 5'd1, rvPkg::opcOpImm));
	storeCheck(5'd1, 32'd7);
	stopWithEbreak();
	busCycles = 0;
	repeat (20) begin
		@(posedge clk);
		#1;
		if (wbReq.cyc)
			busCycles++;
	end
	if (busCycles != 0) begin
		$display("bus cycle seen after ebreak stop");
		testErrors++;
	end
	if (halted != 1'b1)
		reportMismatch("halted", 32'(halted), 32'd1);
	finishTest("ebreak");
endtask

task automatic illegalTest();
	int idx;
	startProgram();
	prog.push_back(encI(32'h123, 5'd0, 3'd0, 5'd1, rvPkg::opcOpImm));
	storeCheck(5'd1, 32'h0000_0123);
	// slli with funct7 = 1
	idx = prog.size();
	prog.push_back(encI(32'h023, 5'd1, 3'd1, 5'd1, rvPkg::opcOpImm));
	storeCheck(5'd1, 32'h0000_0123);
	// the second store must never run
	expVal[1] = addrOf(memIndex(dataBase + 32'd4)) ^ 32'hC3A5_0F96;
	runProgram(idx, 1'b1);
	finishTest("illegal");
endtask

`endif

// File: dv/tbTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbTop;

	// about 5 x 40 instructions x 9 cycles, doubled for margin
	localparam int cycleLimit = 4000;
	localparam int memWords = 2048;
	// data area above the program
	localparam logic [31:0] dataBase = 32'h8000_1000;

	logic clk;
	logic reset;
	busPkg::wbReqT wbReq;
	busPkg::wbRspT wbRsp;
	logic [31:0] pc;
	logic halted;
	logic invalid;

	// unified word memory based at resetPc
	logic [31:0] mem [0:memWords-1];
	int cycles = 0;
	int errors;
	int testErrors;
	int testsRun;
	int testsFailed;

	// program under construction and expected stores
	logic [31:0] prog [$];
	int expOff [$];
	logic [31:0] expVal [$];
	int storeOff;

	rvCoreTop rvCoreTop_i (
		.clk(clk),
		.reset(reset),
		.wbReq(wbReq),
		.wbRsp(wbRsp),
		.pc(pc),
		.halted(halted),
		.invalid(invalid)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic int memIndex(input logic [31:0] adr);
		logic [31:0] off;
		off = (adr - rvPkg::resetPc) >> 2;
		return int'(off[10:0]);
	endfunction

	// wishbone slave with 0 to 3 wait cycles
	// responds 1 ns after the edge
	initial begin
		int waitLeft;
		logic busy;
		int idx;
		void'($urandom(32158));
		wbRsp = '0;
		busy = 1'b0;
		waitLeft = 0;
		forever begin
			@(posedge clk);
			#1;
			if (reset) begin
				wbRsp.ack = 1'b0;
				busy = 1'b0;
			end else if (wbRsp.ack) begin
				// master sampled ack at this edge
				wbRsp.ack = 1'b0;
			end else if (wbReq.cyc && wbReq.stb) begin
				if (!busy) begin
					busy = 1'b1;
					waitLeft = $urandom % 4;
				end
				if (waitLeft == 0) begin
					idx = memIndex(wbReq.adr);
					if (wbReq.we) begin
						for (int b = 0; b < busPkg::selWidth; b++) begin
							if (wbReq.sel[b])
								mem[idx][8*b +: 8] = wbReq.datW[8*b +: 8];
						end
					end
					wbRsp.datR = mem[idx];
					wbRsp.ack = 1'b1;
					busy = 1'b0;
				end else begin
					waitLeft--;
				end
			end
		end
	end

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit) begin
			$display("timeout: core did not halt within %0d cycles", cycleLimit);
			$display("TB FAILED");
			$finish;
		end
	end

	`include "tbTests.svh"

	initial begin
		// held until the first test releases it
		reset = 1'b1;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		repeat (5) @(posedge clk);
		arithTest();
		memoryTest();
		controlFlowTest();
		ebreakTest();
		illegalTest();
		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
+incdir+dv
src/rvPkg.sv
src/busPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/alu.sv
src/loadStoreAlign.sv
src/coreControl.sv
src/rvCoreTop.sv
dv/tbTop.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal --top-module tbTop -f list.f -o simv > build.log 2>&1 &&
./obj_dir/simv > sim.log 2>&1 || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
